// ==== src/video_timing_pkg.sv ====
package video_timing_pkg;

   //////////////////////////////////////////////////
   // raster position types
   //////////////////////////////////////////////////

   // pixel number on the current line, up to 2047
   typedef logic [10:0] hcount_t;

   // line number within the frame, up to 1023
   typedef logic [9:0] vcount_t;

   // beam position and the levels that belong to it
   // hsync and vsync are active low
   typedef struct packed {
      hcount_t hcount;
      vcount_t vcount;
      logic    hsync;
      logic    vsync;
      logic    blank;
   } raster_t;

   //////////////////////////////////////////////////
   // xga 1024x768 at 60 Hz, 65 MHz pixel clock
   //////////////////////////////////////////////////

   // horizontal, in pixels
   localparam int XGA_H_ACTIVE     = 1024;
   localparam int XGA_H_SYNC_START = 1048;
   localparam int XGA_H_SYNC_END   = 1184;
   localparam int XGA_H_TOTAL      = 1344;

   // vertical, in lines
   localparam int XGA_V_ACTIVE     = 768;
   localparam int XGA_V_SYNC_START = 777;
   localparam int XGA_V_SYNC_END   = 783;
   localparam int XGA_V_TOTAL      = 806;

   // how far ahead of the beam the frame buffer is read, in pixels
   // covers the 2 cycle memory latency plus latch and display stages
   localparam int PREFETCH_DEFAULT = 8;

endpackage

// ==== src/vram_pkg.sv ====
package vram_pkg;

   //////////////////////////////////////////////////
   // frame buffer memory types
   //////////////////////////////////////////////////

   // word address: zero bit, line (10 bits), word column (8 bits)
   typedef logic [18:0] vram_addr_t;

   // zbt word, parity bits 35:32 unused
   // bits 31:24 hold the leftmost pixel of the group
   typedef logic [35:0] vram_word_t;

   // 8 bit grey level
   typedef logic [7:0] pixel_t;

   // pixels packed into one memory word
   localparam int PIXELS_PER_WORD = 4;

   // one request per cycle to the memory port
   // we low means a read of addr
   typedef struct packed {
      logic       we;
      vram_addr_t addr;
      vram_word_t wdata;
   } vram_req_t;

   //////////////////////////////////////////////////
   // mode selects
   //////////////////////////////////////////////////

   // display source
   // PIX_BARS shows hardwired bars that never touch memory
   typedef enum logic {
      PIX_VRAM = 1'b0,
      PIX_BARS = 1'b1
   } pixel_src_e;

   // width of the test bars written during blanking
   typedef enum logic {
      BAR_WIDE   = 1'b0,
      BAR_NARROW = 1'b1
   } bar_period_e;

endpackage

// ==== src/raster_timing.sv ====
module raster_timing #(
   parameter int H_ACTIVE     = video_timing_pkg::XGA_H_ACTIVE,
   parameter int H_SYNC_START = video_timing_pkg::XGA_H_SYNC_START,
   parameter int H_SYNC_END   = video_timing_pkg::XGA_H_SYNC_END,
   parameter int H_TOTAL      = video_timing_pkg::XGA_H_TOTAL,
   parameter int V_ACTIVE     = video_timing_pkg::XGA_V_ACTIVE,
   parameter int V_SYNC_START = video_timing_pkg::XGA_V_SYNC_START,
   parameter int V_SYNC_END   = video_timing_pkg::XGA_V_SYNC_END,
   parameter int V_TOTAL      = video_timing_pkg::XGA_V_TOTAL
) (
   input  logic                       clk,
   input  logic                       rst_n,
   output video_timing_pkg::raster_t  raster
);

   // last pixel of a line and last line of a frame
   localparam video_timing_pkg::hcount_t H_LAST = video_timing_pkg::hcount_t'(H_TOTAL - 1);
   localparam video_timing_pkg::vcount_t V_LAST = video_timing_pkg::vcount_t'(V_TOTAL - 1);

   video_timing_pkg::hcount_t h_next;
   video_timing_pkg::vcount_t v_next;

   //////////////////////////////////////////////////
   // next beam position
   //////////////////////////////////////////////////

   always_comb begin
      h_next = raster.hcount + video_timing_pkg::hcount_t'(1);
      v_next = raster.vcount;
      // end of line, step to the next line
      if (raster.hcount == H_LAST) begin
         h_next = '0;
         // end of frame, back to the top
         if (raster.vcount == V_LAST) begin
            v_next = '0;
         end else begin
            v_next = raster.vcount + video_timing_pkg::vcount_t'(1);
         end
      end
   end

   //////////////////////////////////////////////////
   // counters and levels
   //////////////////////////////////////////////////

   // levels are decoded from the next count
   // so they line up with the count they describe
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         raster <= '{hcount: '0, vcount: '0, hsync: 1'b1, vsync: 1'b1, blank: 1'b0};
      end else begin
         raster.hcount <= h_next;
         raster.vcount <= v_next;
         // sync pulses, active low
         raster.hsync <= !((h_next >= H_SYNC_START) && (h_next < H_SYNC_END));
         raster.vsync <= !((v_next >= V_SYNC_START) && (v_next < V_SYNC_END));
         // outside the visible window on either axis
         raster.blank <= (h_next >= H_ACTIVE) || (v_next >= V_ACTIVE);
      end
   end

endmodule

// ==== src/vram_arbiter.sv ====
module vram_arbiter (
   input  logic                       clk,
   input  logic                       rst_n,
   input  video_timing_pkg::raster_t  raster,
   input  vram_pkg::vram_addr_t       read_addr,
   input  vram_pkg::bar_period_e      bar_period,
   output vram_pkg::vram_req_t        vram_req
);

   // free running pattern counter
   logic [31:0] count;

   // one grey level of the test bars
   vram_pkg::pixel_t bar_level;

   //////////////////////////////////////////////////
   // test bar pattern
   //////////////////////////////////////////////////

   // counts cycles since reset was released
   // its low bits sweep the whole frame buffer
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count <= '0;
      end else begin
         count <= count + 32'd1;
      end
   end

   // grey level changes every 8 or 16 words
   always_comb begin
      if (bar_period == vram_pkg::BAR_NARROW) begin
         bar_level = {count[6:3], 4'b0000};
      end else begin
         bar_level = {count[7:4], 4'b0000};
      end
   end

   //////////////////////////////////////////////////
   // memory port sharing
   //////////////////////////////////////////////////

   // blanking belongs to the pattern writer
   // active video belongs to the display reads
   // blank is low in reset, so no write goes out then
   always_comb begin
      vram_req.we    = raster.blank;
      vram_req.wdata = {4'b0000, {vram_pkg::PIXELS_PER_WORD{bar_level}}};
      if (raster.blank) begin
         vram_req.addr = count[18:0];
      end else begin
         vram_req.addr = read_addr;
      end
   end

endmodule

// ==== src/vram_pixel_fetch.sv ====
module vram_pixel_fetch #(
   parameter int H_TOTAL  = video_timing_pkg::XGA_H_TOTAL,
   parameter int V_TOTAL  = video_timing_pkg::XGA_V_TOTAL,
   parameter int PREFETCH = video_timing_pkg::PREFETCH_DEFAULT
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  video_timing_pkg::raster_t  raster,
   input  vram_pkg::vram_word_t       vram_rdata,
   output vram_pkg::vram_addr_t       read_addr,
   output vram_pkg::pixel_t           fetch_pixel
);

   // first hcount whose forecast runs into the next line
   localparam video_timing_pkg::hcount_t H_WRAP =
      video_timing_pkg::hcount_t'(H_TOTAL - PREFETCH);
   localparam video_timing_pkg::hcount_t H_AHEAD = video_timing_pkg::hcount_t'(PREFETCH);
   localparam video_timing_pkg::vcount_t V_LAST = video_timing_pkg::vcount_t'(V_TOTAL - 1);

   // forecast beam position
   video_timing_pkg::hcount_t hcount_f;
   video_timing_pkg::vcount_t vcount_f;

   // pixel slot inside the current word
   logic [1:0] hc4;

   // word as returned by memory, then the word on screen
   vram_pkg::vram_word_t latched_word;
   vram_pkg::vram_word_t disp_word;

   //////////////////////////////////////////////////
   // look-ahead address
   //////////////////////////////////////////////////

   always_comb begin
      if (raster.hcount >= H_WRAP) begin
         // forecast lands at the start of the next line
         hcount_f = raster.hcount - H_WRAP;
         if (raster.vcount == V_LAST) begin
            vcount_f = '0;
         end else begin
            vcount_f = raster.vcount + video_timing_pkg::vcount_t'(1);
         end
      end else begin
         hcount_f = raster.hcount + H_AHEAD;
         vcount_f = raster.vcount;
      end
   end

   // four pixels per word, so the column drops its two low bits
   assign read_addr = {1'b0, vcount_f, hcount_f[9:2]};

   //////////////////////////////////////////////////
   // read word pipeline
   //////////////////////////////////////////////////

   assign hc4 = raster.hcount[1:0];

   // data addressed two cycles back is on the bus at slot 1
   // it goes on screen for the four slots after slot 3
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         latched_word <= '0;
         disp_word    <= '0;
      end else begin
         if (hc4 == 2'd1) begin
            latched_word <= vram_rdata;
         end
         if (hc4 == 2'd3) begin
            disp_word <= latched_word;
         end
      end
   end

   // leftmost pixel sits in the top byte
   assign fetch_pixel = disp_word[(vram_pkg::PIXELS_PER_WORD - 1 - int'(hc4)) * 8 +: 8];

endmodule

// ==== src/pixel_output.sv ====
module pixel_output (
   input  logic                       clk,
   input  logic                       rst_n,
   input  video_timing_pkg::raster_t  raster,
   input  vram_pkg::pixel_t           fetch_pixel,
   input  vram_pkg::pixel_src_e       pixel_src,
   output vram_pkg::pixel_t           pixel,
   output video_timing_pkg::raster_t  raster_out
);

   vram_pkg::pixel_t pixel_sel;

   //////////////////////////////////////////////////
   // source select
   //////////////////////////////////////////////////

   // vertical bars, 64 pixels wide, eight grey levels
   always_comb begin
      if (pixel_src == vram_pkg::PIX_BARS) begin
         pixel_sel = {raster.hcount[8:6], 5'b00000};
      end else begin
         pixel_sel = fetch_pixel;
      end
   end

   //////////////////////////////////////////////////
   // output register
   //////////////////////////////////////////////////

   // pixel and raster leave on the same edge
   always_ff @(posedge clk) begin
      pixel <= pixel_sel;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         raster_out <= '{hcount: '0, vcount: '0, hsync: 1'b1, vsync: 1'b1, blank: 1'b0};
      end else begin
         raster_out <= raster;
      end
   end

endmodule

// ==== src/zbt_video_top.sv ====
module zbt_video_top #(
   parameter int H_ACTIVE     = video_timing_pkg::XGA_H_ACTIVE,
   parameter int H_SYNC_START = video_timing_pkg::XGA_H_SYNC_START,
   parameter int H_SYNC_END   = video_timing_pkg::XGA_H_SYNC_END,
   parameter int H_TOTAL      = video_timing_pkg::XGA_H_TOTAL,
   parameter int V_ACTIVE     = video_timing_pkg::XGA_V_ACTIVE,
   parameter int V_SYNC_START = video_timing_pkg::XGA_V_SYNC_START,
   parameter int V_SYNC_END   = video_timing_pkg::XGA_V_SYNC_END,
   parameter int V_TOTAL      = video_timing_pkg::XGA_V_TOTAL,
   // H_TOTAL - H_ACTIVE must be at least PREFETCH
   parameter int PREFETCH     = video_timing_pkg::PREFETCH_DEFAULT
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  vram_pkg::pixel_src_e       pixel_src,
   input  vram_pkg::bar_period_e      bar_period,
   input  vram_pkg::vram_word_t       vram_rdata,
   output vram_pkg::vram_req_t        vram_req,
   output vram_pkg::pixel_t           pixel,
   output video_timing_pkg::raster_t  raster_out
);

   // beam position, shared by every stage
   video_timing_pkg::raster_t raster;

   // display read address and the pixel it produced
   vram_pkg::vram_addr_t read_addr;
   vram_pkg::pixel_t     fetch_pixel;

   //////////////////////////////////////////////////
   // decode
   //////////////////////////////////////////////////

   raster_timing #(
      .H_ACTIVE     (H_ACTIVE),
      .H_SYNC_START (H_SYNC_START),
      .H_SYNC_END   (H_SYNC_END),
      .H_TOTAL      (H_TOTAL),
      .V_ACTIVE     (V_ACTIVE),
      .V_SYNC_START (V_SYNC_START),
      .V_SYNC_END   (V_SYNC_END),
      .V_TOTAL      (V_TOTAL)
   ) i_raster_timing (
      .clk    (clk),
      .rst_n  (rst_n),
      .raster (raster)
   );

   //////////////////////////////////////////////////
   // execute
   //////////////////////////////////////////////////

   vram_arbiter i_vram_arbiter (
      .clk        (clk),
      .rst_n      (rst_n),
      .raster     (raster),
      .read_addr  (read_addr),
      .bar_period (bar_period),
      .vram_req   (vram_req)
   );

   vram_pixel_fetch #(
      .H_TOTAL  (H_TOTAL),
      .V_TOTAL  (V_TOTAL),
      .PREFETCH (PREFETCH)
   ) i_vram_pixel_fetch (
      .clk         (clk),
      .rst_n       (rst_n),
      .raster      (raster),
      .vram_rdata  (vram_rdata),
      .read_addr   (read_addr),
      .fetch_pixel (fetch_pixel)
   );

   //////////////////////////////////////////////////
   // result
   //////////////////////////////////////////////////

   pixel_output i_pixel_output (
      .clk         (clk),
      .rst_n       (rst_n),
      .raster      (raster),
      .fetch_pixel (fetch_pixel),
      .pixel_src   (pixel_src),
      .pixel       (pixel),
      .raster_out  (raster_out)
   );

endmodule

// ==== verification/tb_zbt_video_ref.svh ====
`ifndef TB_ZBT_VIDEO_REF_SVH
`define TB_ZBT_VIDEO_REF_SVH

//////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////

// beam position n cycles after the start of the first frame
// with the sync and blank levels that belong to it
function automatic video_timing_pkg::raster_t expected_raster(input int n);
   video_timing_pkg::raster_t r;
   int h;
   int v;
   h = n % H_TOTAL;
   v = (n / H_TOTAL) % V_TOTAL;
   r.hcount = video_timing_pkg::hcount_t'(h);
   r.vcount = video_timing_pkg::vcount_t'(v);
   // syncs are active low
   r.hsync = !((h >= H_SYNC_START) && (h < H_SYNC_END));
   r.vsync = !((v >= V_SYNC_START) && (v < V_SYNC_END));
   r.blank = (h >= H_ACTIVE) || (v >= V_ACTIVE);
   return r;
endfunction

// hardwired bars, 64 pixels per grey step
function automatic vram_pkg::pixel_t bar_pixel(input int h);
   return vram_pkg::pixel_t'(((h / 64) % 8) * 32);
endfunction

// pattern counter model, its low 19 bits are the write address
function automatic vram_pkg::vram_addr_t pattern_addr(input int count);
   return vram_pkg::vram_addr_t'(count % MEM_WORDS);
endfunction

// one grey level repeated over the four pixels of a word
function automatic vram_pkg::vram_word_t pattern_word(input int count,
                                                      input vram_pkg::bar_period_e period);
   int level;
   if (period == vram_pkg::BAR_NARROW) begin
      level = (count / 8) % 16;
   end else begin
      level = (count / 16) % 16;
   end
   return {4'h0, {4{8'(level * 16)}}};
endfunction

// zero bit, line, then column of four pixels
function automatic int word_addr(input int h, input int v);
   return v * 256 + h / 4;
endfunction

// leftmost pixel in the top byte
function automatic vram_pkg::pixel_t frame_pixel(input int h, input int v);
   vram_pkg::vram_word_t w;
   w = mem[word_addr(h, v)];
   return w[(3 - h % 4) * 8 +: 8];
endfunction

function automatic bit written_lately(input int h, input int v);
   return (longint'($time) - last_write[word_addr(h, v)]) < RECENT_WINDOW;
endfunction

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
   if (got !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, expected);
      $display("Something failed");
      $fatal(1, "stopped at the first wrong value");
   end
endtask

`endif

// ==== verification/tb_zbt_video.sv ====
module tb_zbt_video;

   //////////////////////////////////////////////////
   // small raster so a frame is 2304 cycles
   //////////////////////////////////////////////////

   localparam int H_ACTIVE     = 64;
   localparam int H_SYNC_START = 72;
   localparam int H_SYNC_END   = 80;
   localparam int H_TOTAL      = 96;
   localparam int V_ACTIVE     = 16;
   localparam int V_SYNC_START = 18;
   localparam int V_SYNC_END   = 20;
   localparam int V_TOTAL      = 24;
   localparam int PREFETCH     = video_timing_pkg::PREFETCH_DEFAULT;

   localparam int     FRAME         = H_TOTAL * V_TOTAL;
   localparam int     CLK_PERIOD    = 40;
   localparam int     RESET_CYCLES  = 16;
   localparam int     MEM_WORDS     = 2 ** 19;
   localparam longint RECENT_WINDOW = 16 * CLK_PERIOD;
   // reset plus four frames
   localparam longint TIMEOUT       = (RESET_CYCLES + 4 * FRAME) * CLK_PERIOD;

   logic                      clk;
   logic                      rst_n;
   vram_pkg::pixel_src_e      pixel_src;
   vram_pkg::bar_period_e     bar_period;
   vram_pkg::vram_word_t      vram_rdata;
   vram_pkg::vram_req_t       vram_req;
   vram_pkg::pixel_t          pixel;
   video_timing_pkg::raster_t raster_out;

   // zbt model contents and time of each word's last write
   vram_pkg::vram_word_t mem [0:MEM_WORDS-1];
   longint               last_write [0:MEM_WORDS-1];
   vram_pkg::vram_word_t rd_pipe;
   int                   error_count;

   `include "tb_zbt_video_ref.svh"

   zbt_video_top #(
      .H_ACTIVE     (H_ACTIVE),
      .H_SYNC_START (H_SYNC_START),
      .H_SYNC_END   (H_SYNC_END),
      .H_TOTAL      (H_TOTAL),
      .V_ACTIVE     (V_ACTIVE),
      .V_SYNC_START (V_SYNC_START),
      .V_SYNC_END   (V_SYNC_END),
      .V_TOTAL      (V_TOTAL),
      .PREFETCH     (PREFETCH)
   ) i_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .pixel_src  (pixel_src),
      .bar_period (bar_period),
      .vram_rdata (vram_rdata),
      .vram_req   (vram_req),
      .pixel      (pixel),
      .raster_out (raster_out)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // memory model
   // writes land at the edge and reads take two edges
   always @(posedge clk) begin
      if (vram_req.we) begin
         mem[vram_req.addr]        <= vram_req.wdata;
         last_write[vram_req.addr] <= longint'($time);
      end
      rd_pipe    <= mem[vram_req.addr];
      vram_rdata <= rd_pipe;
   end

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////

   initial begin
      void'($urandom(32'hdf89));
      for (int a = 0; a < MEM_WORDS; a++) begin
         mem[a]        = vram_pkg::vram_word_t'({$urandom, $urandom});
         last_write[a] = -TIMEOUT;
      end
      rst_n       = 1'b0;
      pixel_src   = vram_pkg::PIX_VRAM;
      bar_period  = vram_pkg::BAR_WIDE;
      vram_rdata  = '0;
      rd_pipe     = '0;
      error_count = 0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      // frame 0 shows the frame buffer
      repeat (FRAME) @(negedge clk);
      // frame 1 shows the hardwired bars with the narrow pattern from mid frame
      pixel_src = vram_pkg::PIX_BARS;
      repeat (FRAME / 2) @(negedge clk);
      bar_period = vram_pkg::BAR_NARROW;
      repeat (FRAME / 2) @(negedge clk);
      pixel_src = vram_pkg::PIX_VRAM;
      repeat (FRAME) @(negedge clk);
      // last frame stops one line short of the watchdog
      bar_period = vram_pkg::BAR_WIDE;
      repeat (FRAME - H_TOTAL) @(negedge clk);
      if (error_count == 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         $display("Something failed");
         $fatal(1, "run ended with errors");
      end
   end

   //////////////////////////////////////////////////
   // comparison of the values seen just before each edge
   //////////////////////////////////////////////////

   initial begin
      int                        n;
      int                        reset_edges;
      video_timing_pkg::raster_t beam;
      video_timing_pkg::raster_t pos;
      vram_pkg::pixel_src_e      prev_src;
      n           = 0;
      reset_edges = 0;
      prev_src    = vram_pkg::PIX_VRAM;
      forever begin
         @(posedge clk);
         if (!rst_n) begin
            // raster is unknown until the first reset edge
            if (reset_edges > 0) begin
               check_value("vram_req.we", vram_req.we, 1'b0);
            end
            reset_edges++;
         end else begin
            // n is also the pattern count
            // raster_out trails the beam by one
            beam = expected_raster(n);
            check_value("vram_req.we", vram_req.we, beam.blank);
            if (vram_req.we) begin
               check_value("vram_req.addr", vram_req.addr, pattern_addr(n));
               check_value("vram_req.wdata", vram_req.wdata, pattern_word(n, bar_period));
            end
            if (n > 0) begin
               pos = expected_raster(n - 1);
               check_value("raster_out", raster_out, pos);
               // the bars keep running through blanking
               if (prev_src == vram_pkg::PIX_BARS) begin
                  check_value("pixel", pixel, bar_pixel(pos.hcount));
               end else if (!pos.blank && pos.hcount >= PREFETCH) begin
                  // first words of a line are requested while blanking owns the port
                  if (!written_lately(pos.hcount, pos.vcount)) begin
                     check_value("pixel", pixel, frame_pixel(pos.hcount, pos.vcount));
                  end
               end
            end
            n++;
         end
         prev_src = pixel_src;
      end
   end

   // watchdog
   initial begin
      #(TIMEOUT);
      $display("Timeout: the run did not finish within %0t time units", TIMEOUT);
      $display("Something failed");
      $fatal(1, "watchdog expired");
   end

endmodule

// ==== zbt_video_top.f ====
+incdir+verification
src/video_timing_pkg.sv
src/vram_pkg.sv
src/raster_timing.sv
src/vram_arbiter.sv
src/vram_pixel_fetch.sv
src/pixel_output.sv
src/zbt_video_top.sv
verification/tb_zbt_video.sv

// ==== Bender.yml ====
package:
  name: zbt_video

sources:
  # packages first, then the rtl from the leaves up to the top level
  - src/video_timing_pkg.sv
  - src/vram_pkg.sv
  - src/raster_timing.sv
  - src/vram_arbiter.sv
  - src/vram_pixel_fetch.sv
  - src/pixel_output.sv
  - src/zbt_video_top.sv

  # testbench, top module tb_zbt_video
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_zbt_video.sv
